// File: vertex_job_control.f
hw/vertex_job_pkg.sv
hw/read_command_pkg.sv
hw/vertex_job_fsm.sv
hw/vertex_chunk_counter.sv
hw/vertex_line_unpacker.sv
hw/vertex_job_fifo.sv
hw/vertex_job_control.sv
sim/vertex_job_control_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, then search the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal \
	--top-module vertex_job_control_tb -f vertex_job_control.f \
	-o vertex_job_control_sim > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }
./obj_dir/vertex_job_control_sim > sim.log 2>&1 || true
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1
grep -q "TESTBENCH PASSED" sim.log || exit 1
exit 0

// File: sim/vertex_job_control_tb.sv
`timescale 1ns/1ps
`default_nettype none

module vertex_job_control_tb;

	import vertex_job_pkg::*;
	import read_command_pkg::*;

	logic                    clock;
	logic                    rstn;
	logic                    job_start;
	logic [ADDRESS_BITS-1:0] job_degree_base;
	logic [ADDRESS_BITS-1:0] job_edges_base;
	logic [COUNT_BITS-1:0]   job_num_vertices;
	logic [VERTEX_BITS-1:0]  job_first_id;
	logic                    cmd_valid;
	logic [ADDRESS_BITS-1:0] cmd_address;
	array_sel_t              cmd_array;
	logic [CHUNK_BITS-1:0]   cmd_count;
	logic                    rd_valid = 1'b0;
	array_sel_t              rd_array = ARRAY_OUT_DEGREE;
	vertex_line_t            rd_data = '0;
	logic                    vertex_request = 1'b0;
	logic                    vertex_ready;
	logic                    vertex_valid;
	logic [VERTEX_BITS-1:0]  vertex_id;
	logic [VERTEX_BITS-1:0]  vertex_out_degree;
	logic [VERTEX_BITS-1:0]  vertex_edges_idx;
	logic                    busy;

	integer seed;
	int     watchdog_cycles = 0;
	int     cycle_count = 0;
	int     cmd_seen;
	int     received;
	logic   job_active;

	// expected values for the command or vertex seen at this edge
	array_sel_t              exp_cmd_array;
	logic [ADDRESS_BITS-1:0] exp_cmd_address;
	logic [31:0]             exp_cmd_count;
	logic [VERTEX_BITS-1:0]  exp_id;
	logic [VERTEX_BITS-1:0]  exp_degree;
	logic [VERTEX_BITS-1:0]  exp_edges;

	// read commands waiting for their answer
	logic [ADDRESS_BITS-1:0] pend_address [$];
	array_sel_t              pend_array [$];
	int                      pend_due [$];

	vertex_job_control uut (
		.clock             (clock),
		.rstn              (rstn),
		.job_start         (job_start),
		.job_degree_base   (job_degree_base),
		.job_edges_base    (job_edges_base),
		.job_num_vertices  (job_num_vertices),
		.job_first_id      (job_first_id),
		.cmd_valid         (cmd_valid),
		.cmd_address       (cmd_address),
		.cmd_array         (cmd_array),
		.cmd_count         (cmd_count),
		.rd_valid          (rd_valid),
		.rd_array          (rd_array),
		.rd_data           (rd_data),
		.vertex_request    (vertex_request),
		.vertex_ready      (vertex_ready),
		.vertex_valid      (vertex_valid),
		.vertex_id         (vertex_id),
		.vertex_out_degree (vertex_out_degree),
		.vertex_edges_idx  (vertex_edges_idx),
		.busy              (busy)
	);

	always begin
		#20 clock = ~clock;
	end

	////////////////////////////////////////
	// memory contents and failure reporting
	////////////////////////////////////////

	// odd multipliers, so every address bit changes the word
	function automatic logic [VERTEX_BITS-1:0] line_word(
		input array_sel_t              arr,
		input logic [ADDRESS_BITS-1:0] address
	);
		if (arr == ARRAY_OUT_DEGREE) begin
			return (address * 32'h9e37_79b1) ^ 32'h0f0f_1234;
		end
		return (address * 32'h85eb_ca6b) + 32'h2545_f491;
	endfunction

	// chunk k starts k lines above the base, entry i adds i
	function automatic logic [ADDRESS_BITS-1:0] vertex_address(
		input logic [ADDRESS_BITS-1:0] base,
		input int                      index
	);
		return base + ADDRESS_BITS'((index / LINE_VERTICES) * LINE_BYTES
			+ index % LINE_VERTICES);
	endfunction

	task automatic abort_run();
		$display("TESTBENCH FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic value_mismatch(
		input string       name,
		input logic [31:0] expected,
		input logic [31:0] actual
	);
		$display("error %s expected %h actual %h", name, expected, actual);
		abort_run();
	endtask

	task automatic plain_failure(input string what);
		$display("%s", what);
		abort_run();
	endtask

	////////////////////////////////////////
	// monitors and expected values
	////////////////////////////////////////

	always @(posedge clock) begin
		if (!rstn) begin
			cmd_seen   <= 0;
			received   <= 0;
			job_active <= 1'b0;
		end else if (job_start) begin
			cmd_seen   <= 0;
			received   <= 0;
			job_active <= 1'b1;
		end else begin
			if (cmd_valid) begin
				cmd_seen <= cmd_seen + 1;
			end
			if (vertex_valid) begin
				received <= received + 1;
				if (received + 1 == int'(job_num_vertices)) begin
					job_active <= 1'b0;
				end
			end
		end
	end

	always_comb begin
		exp_cmd_array   = cmd_seen[0] ? ARRAY_EDGES_IDX : ARRAY_OUT_DEGREE;
		exp_cmd_address = (cmd_seen[0] ? job_edges_base : job_degree_base)
			+ ADDRESS_BITS'((cmd_seen / 2) * LINE_BYTES);
		exp_cmd_count   = job_num_vertices - 32'((cmd_seen / 2) * LINE_VERTICES);
		if (exp_cmd_count > LINE_VERTICES) begin
			exp_cmd_count = LINE_VERTICES;
		end
		exp_id     = job_first_id + VERTEX_BITS'(received);
		exp_degree = line_word(ARRAY_OUT_DEGREE, vertex_address(job_degree_base, received));
		exp_edges  = line_word(ARRAY_EDGES_IDX, vertex_address(job_edges_base, received));
	end

	////////////////////////////////////////
	// memory responder and consumer
	////////////////////////////////////////

	// answers the first due command, so edges may overtake degree
	always @(posedge clock) begin : responder
		vertex_line_t line;
		int           slot;
		int           i;
		slot = -1;
		cycle_count = cycle_count + 1;
		for (i = 0; i < pend_due.size(); i++) begin
			if (slot < 0 && pend_due[i] <= cycle_count) begin
				slot = i;
			end
		end
		if (slot >= 0) begin
			for (i = 0; i < LINE_VERTICES; i++) begin
				line.entry[i] = line_word(pend_array[slot],
					pend_address[slot] + ADDRESS_BITS'(i));
			end
			rd_valid <= 1'b1;
			rd_array <= pend_array[slot];
			rd_data  <= line;
			pend_address.delete(slot);
			pend_array.delete(slot);
			pend_due.delete(slot);
		end else begin
			rd_valid <= 1'b0;
		end
		if (cmd_valid) begin
			pend_address.push_back(cmd_address);
			pend_array.push_back(cmd_array);
			pend_due.push_back(cycle_count + 1 + int'($unsigned($random(seed)) % 6));
		end
	end

	// a pop in flight may empty the queue, so never two requests in a row
	always @(posedge clock) begin : consumer
		if (!rstn) begin
			vertex_request <= 1'b0;
		end else begin
			vertex_request <= vertex_ready && !vertex_request
				&& (($random(seed) & 3) != 0);
		end
	end

	////////////////////////////////////////
	// checks
	////////////////////////////////////////

	reset_state: assert property (@(posedge clock)
		$rose(rstn) |-> !cmd_valid && !vertex_valid && !busy && !vertex_ready)
		else plain_failure("outputs were not low after reset");

	start_latency: assert property (@(posedge clock) disable iff (!rstn)
		$past(job_start, 3) |-> cmd_valid && cmd_array == ARRAY_OUT_DEGREE)
		else plain_failure("first degree command did not come 3 cycles after job_start");

	busy_rise: assert property (@(posedge clock) disable iff (!rstn)
		job_start |=> busy)
		else plain_failure("busy did not rise the cycle after job_start");

	edges_follow: assert property (@(posedge clock) disable iff (!rstn)
		cmd_valid && cmd_array == ARRAY_OUT_DEGREE |=> cmd_valid && cmd_array == ARRAY_EDGES_IDX)
		else plain_failure("edges command did not follow the degree command");

	cmd_order: assert property (@(posedge clock) disable iff (!rstn)
		cmd_valid |-> cmd_array == exp_cmd_array)
		else value_mismatch("cmd_order", 32'($sampled(exp_cmd_array)),
			32'($sampled(cmd_array)));

	cmd_address_check: assert property (@(posedge clock) disable iff (!rstn)
		cmd_valid |-> cmd_address == exp_cmd_address)
		else value_mismatch("cmd_address", $sampled(exp_cmd_address), $sampled(cmd_address));

	cmd_count_check: assert property (@(posedge clock) disable iff (!rstn)
		cmd_valid |-> 32'(cmd_count) == exp_cmd_count)
		else value_mismatch("cmd_count", $sampled(exp_cmd_count), 32'($sampled(cmd_count)));

	request_latency: assert property (@(posedge clock) disable iff (!rstn)
		vertex_request |=> vertex_valid)
		else plain_failure("vertex_valid did not follow vertex_request by one cycle");

	valid_source: assert property (@(posedge clock) disable iff (!rstn)
		vertex_valid |-> $past(vertex_request))
		else plain_failure("vertex_valid came without a request one cycle before");

	vertex_id_check: assert property (@(posedge clock) disable iff (!rstn)
		vertex_valid |-> vertex_id == exp_id)
		else value_mismatch("vertex_id", $sampled(exp_id), $sampled(vertex_id));

	vertex_degree_check: assert property (@(posedge clock) disable iff (!rstn)
		vertex_valid |-> vertex_out_degree == exp_degree)
		else value_mismatch("vertex_out_degree", $sampled(exp_degree),
			$sampled(vertex_out_degree));

	vertex_edges_check: assert property (@(posedge clock) disable iff (!rstn)
		vertex_valid |-> vertex_edges_idx == exp_edges)
		else value_mismatch("vertex_edges_idx", $sampled(exp_edges), $sampled(vertex_edges_idx));

	// idle with nothing queued while vertices are still owed
	job_end: assert property (@(posedge clock) disable iff (!rstn)
		job_active && !busy |-> vertex_ready || vertex_valid || vertex_request)
		else value_mismatch("job_end", $sampled(job_num_vertices), 32'($sampled(received)));

	extra_vertex: assert property (@(posedge clock) disable iff (!rstn)
		!job_active && !busy |-> !vertex_ready)
		else plain_failure("a vertex was queued beyond the job's vertex count");

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////

	task automatic run_job(
		input logic [ADDRESS_BITS-1:0] degree_base,
		input logic [ADDRESS_BITS-1:0] edges_base,
		input int                      count,
		input logic [VERTEX_BITS-1:0]  first_id
	);
		@(posedge clock);
		job_degree_base  <= degree_base;
		job_edges_base   <= edges_base;
		job_num_vertices <= COUNT_BITS'(count);
		job_first_id     <= first_id;
		job_start        <= 1'b1;
		@(posedge clock);
		job_start <= 1'b0;
		@(posedge clock);
		// consumer drains the queue by itself
		while (job_active) begin
			@(posedge clock);
		end
		while (busy) begin
			@(posedge clock);
		end
	endtask

	initial begin : stimulus
		int second_count;
		seed             = 32'hc063;
		clock            = 1'b0;
		rstn             = 1'b0;
		job_start        = 1'b0;
		job_degree_base  = '0;
		job_edges_base   = '0;
		job_num_vertices = '0;
		job_first_id     = '0;
		second_count     = 1 + int'($unsigned($random(seed)) % 29);
		watchdog_cycles  = (10 + second_count) * 20 + 500;
		repeat (4) @(posedge clock);
		rstn <= 1'b1;
		// chunks of 4, 4 and 2
		run_job(32'h0001_0000, 32'h0002_0400, 10, 32'd100);
		run_job(32'h0040_0100, 32'h0080_2a40, second_count, 32'h0000_1000);
		repeat (4) @(posedge clock);
		$display("TESTBENCH PASSED");
		$finish;
	end

	initial begin : watchdog
		wait (watchdog_cycles != 0);
		repeat (watchdog_cycles) @(posedge clock);
		plain_failure("timeout, the jobs did not finish in time");
	end

endmodule

`default_nettype wire

// File: hw/vertex_job_control.sv
`timescale 1ns/1ps
`default_nettype none

module vertex_job_control (
	input  logic                                   clock,
	input  logic                                   rstn,
	input  logic                                   job_start,
	input  logic [vertex_job_pkg::ADDRESS_BITS-1:0] job_degree_base,
	input  logic [vertex_job_pkg::ADDRESS_BITS-1:0] job_edges_base,
	input  logic [vertex_job_pkg::COUNT_BITS-1:0]   job_num_vertices,
	input  logic [vertex_job_pkg::VERTEX_BITS-1:0]  job_first_id,
	output logic                                   cmd_valid,
	output logic [vertex_job_pkg::ADDRESS_BITS-1:0] cmd_address,
	output read_command_pkg::array_sel_t           cmd_array,
	output logic [read_command_pkg::CHUNK_BITS-1:0] cmd_count,
	input  logic                                   rd_valid,
	input  read_command_pkg::array_sel_t           rd_array,
	input  vertex_job_pkg::vertex_line_t           rd_data,
	input  logic                                   vertex_request,
	output logic                                   vertex_ready,
	output logic                                   vertex_valid,
	output logic [vertex_job_pkg::VERTEX_BITS-1:0]  vertex_id,
	output logic [vertex_job_pkg::VERTEX_BITS-1:0]  vertex_out_degree,
	output logic [vertex_job_pkg::VERTEX_BITS-1:0]  vertex_edges_idx,
	output logic                                   busy
);

	import vertex_job_pkg::*;

	logic                   chunk_load;
	logic                   issue_degree;
	logic                   issue_edges;
	logic                   shift_start;
	logic                   shift_done;
	logic                   line_pair_ready;
	logic                   remaining_zero;
	logic                   fifo_empty;
	logic                   push;
	logic [VERTEX_BITS-1:0] push_id;
	logic [VERTEX_BITS-1:0] push_degree;
	logic [VERTEX_BITS-1:0] push_edges;

	vertex_job_fsm fsm (
		.clock           (clock),
		.rstn            (rstn),
		.job_start       (job_start),
		.fifo_empty      (fifo_empty),
		.remaining_zero  (remaining_zero),
		.line_pair_ready (line_pair_ready),
		.shift_done      (shift_done),
		.chunk_load      (chunk_load),
		.issue_degree    (issue_degree),
		.issue_edges     (issue_edges),
		.shift_start     (shift_start),
		.busy            (busy)
	);

	// command side
	vertex_chunk_counter counter (
		.clock            (clock),
		.rstn             (rstn),
		.chunk_load       (chunk_load),
		.issue_degree     (issue_degree),
		.issue_edges      (issue_edges),
		.job_degree_base  (job_degree_base),
		.job_edges_base   (job_edges_base),
		.job_num_vertices (job_num_vertices),
		.remaining_zero   (remaining_zero),
		.cmd_valid        (cmd_valid),
		.cmd_address      (cmd_address),
		.cmd_array        (cmd_array),
		.cmd_count        (cmd_count)
	);

	// data side
	vertex_line_unpacker unpacker (
		.clock            (clock),
		.rstn             (rstn),
		.rd_valid         (rd_valid),
		.rd_array         (rd_array),
		.rd_data          (rd_data),
		.shift_start      (shift_start),
		.job_first_id     (job_first_id),
		.job_num_vertices (job_num_vertices),
		.chunk_load       (chunk_load),
		.line_pair_ready  (line_pair_ready),
		.shift_done       (shift_done),
		.push             (push),
		.push_id          (push_id),
		.push_degree      (push_degree),
		.push_edges       (push_edges)
	);

	vertex_job_fifo job_fifo (
		.clock             (clock),
		.rstn              (rstn),
		.push              (push),
		.push_id           (push_id),
		.push_degree       (push_degree),
		.push_edges        (push_edges),
		.vertex_request    (vertex_request),
		.fifo_empty        (fifo_empty),
		.vertex_ready      (vertex_ready),
		.vertex_valid      (vertex_valid),
		.vertex_id         (vertex_id),
		.vertex_out_degree (vertex_out_degree),
		.vertex_edges_idx  (vertex_edges_idx)
	);

endmodule

`default_nettype wire

// File: hw/vertex_job_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module vertex_job_fifo (
	input  logic                                  clock,
	input  logic                                  rstn,
	input  logic                                  push,
	input  logic [vertex_job_pkg::VERTEX_BITS-1:0] push_id,
	input  logic [vertex_job_pkg::VERTEX_BITS-1:0] push_degree,
	input  logic [vertex_job_pkg::VERTEX_BITS-1:0] push_edges,
	input  logic                                  vertex_request,
	output logic                                  fifo_empty,
	output logic                                  vertex_ready,
	output logic                                  vertex_valid,
	output logic [vertex_job_pkg::VERTEX_BITS-1:0] vertex_id,
	output logic [vertex_job_pkg::VERTEX_BITS-1:0] vertex_out_degree,
	output logic [vertex_job_pkg::VERTEX_BITS-1:0] vertex_edges_idx
);

	import vertex_job_pkg::*;

	// id, degree, edge index packed into one entry
	logic [3*VERTEX_BITS-1:0]                  mem [VERTEX_FIFO_DEPTH];
	logic [$clog2(VERTEX_FIFO_DEPTH)-1:0]      wr_ptr;
	logic [$clog2(VERTEX_FIFO_DEPTH)-1:0]      rd_ptr;
	logic [$clog2(VERTEX_FIFO_DEPTH+1)-1:0]    count;
	logic                                      pop;
	logic                                      full;

	assign fifo_empty   = (count == '0);
	assign vertex_ready = !fifo_empty;
	assign full         = (count == VERTEX_FIFO_DEPTH);
	assign pop          = vertex_request && vertex_ready;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr       <= '0;
			rd_ptr       <= '0;
			count        <= '0;
			vertex_valid <= 1'b0;
		end else begin
			vertex_valid <= pop;
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (push) begin
			mem[wr_ptr] <= {push_id, push_degree, push_edges};
		end
		if (pop) begin
			{vertex_id, vertex_out_degree, vertex_edges_idx} <= mem[rd_ptr];
		end
	end

	// unpacker never outruns the queue, consumer never pops air
	no_push_full: assert property (@(posedge clock) disable iff (!rstn)
		push |-> !full);
	no_pop_empty: assert property (@(posedge clock) disable iff (!rstn)
		vertex_request |-> vertex_ready);

endmodule

`default_nettype wire

// File: hw/vertex_line_unpacker.sv
`timescale 1ns/1ps
`default_nettype none

module vertex_line_unpacker (
	input  logic                                   clock,
	input  logic                                   rstn,
	input  logic                                   rd_valid,
	input  read_command_pkg::array_sel_t           rd_array,
	input  vertex_job_pkg::vertex_line_t           rd_data,
	input  logic                                   shift_start,
	input  logic [vertex_job_pkg::VERTEX_BITS-1:0]  job_first_id,
	input  logic [vertex_job_pkg::COUNT_BITS-1:0]   job_num_vertices,
	input  logic                                   chunk_load,
	output logic                                   line_pair_ready,
	output logic                                   shift_done,
	output logic                                   push,
	output logic [vertex_job_pkg::VERTEX_BITS-1:0]  push_id,
	output logic [vertex_job_pkg::VERTEX_BITS-1:0]  push_degree,
	output logic [vertex_job_pkg::VERTEX_BITS-1:0]  push_edges
);

	import vertex_job_pkg::*;
	import read_command_pkg::*;

	vertex_line_t            degree_line;
	vertex_line_t            edges_line;
	logic                    degree_ready;
	logic                    edges_ready;
	logic [COUNT_BITS-1:0]   remaining;
	logic [CHUNK_BITS-1:0]   chunk;
	logic [CHUNK_BITS-1:0]   shift_left;
	logic [VERTEX_BITS-1:0]  id_counter;

	assign line_pair_ready = degree_ready && edges_ready;

	// same chunk rule as the command side
	assign chunk = (remaining > COUNT_BITS'(LINE_VERTICES)) ?
		CHUNK_BITS'(LINE_VERTICES) : remaining[CHUNK_BITS-1:0];

	////////////////////////////////////////
	// line capture
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (rd_valid && rd_array == ARRAY_OUT_DEGREE) begin
			degree_line.word <= rd_data.word;
		end else if (shift_left != '0) begin
			degree_line.word <= degree_line.word >> VERTEX_BITS;
		end
		if (rd_valid && rd_array == ARRAY_EDGES_IDX) begin
			edges_line.word <= rd_data.word;
		end else if (shift_left != '0) begin
			edges_line.word <= edges_line.word >> VERTEX_BITS;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			degree_ready <= 1'b0;
			edges_ready  <= 1'b0;
		end else if (shift_start) begin
			degree_ready <= 1'b0;
			edges_ready  <= 1'b0;
		end else if (rd_valid) begin
			degree_ready <= degree_ready || (rd_array == ARRAY_OUT_DEGREE);
			edges_ready  <= edges_ready || (rd_array == ARRAY_EDGES_IDX);
		end
	end

	////////////////////////////////////////
	// shift out, one vertex per cycle
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			remaining  <= '0;
			shift_left <= '0;
			push       <= 1'b0;
			shift_done <= 1'b0;
		end else begin
			push       <= (shift_left != '0);
			shift_done <= (shift_left == CHUNK_BITS'(1));
			if (chunk_load) begin
				remaining <= job_num_vertices;
			end else if (shift_start) begin
				remaining  <= remaining - COUNT_BITS'(chunk);
				shift_left <= chunk;
			end else if (shift_left != '0) begin
				shift_left <= shift_left - 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (chunk_load) begin
			id_counter <= job_first_id;
		end else if (shift_left != '0) begin
			id_counter <= id_counter + 1'b1;
		end
		// entry 0 is always the next vertex
		push_id     <= id_counter;
		push_degree <= degree_line.entry[0];
		push_edges  <= edges_line.entry[0];
	end

endmodule

`default_nettype wire

// File: hw/vertex_chunk_counter.sv
`timescale 1ns/1ps
`default_nettype none

module vertex_chunk_counter (
	input  logic                                   clock,
	input  logic                                   rstn,
	input  logic                                   chunk_load,
	input  logic                                   issue_degree,
	input  logic                                   issue_edges,
	input  logic [vertex_job_pkg::ADDRESS_BITS-1:0] job_degree_base,
	input  logic [vertex_job_pkg::ADDRESS_BITS-1:0] job_edges_base,
	input  logic [vertex_job_pkg::COUNT_BITS-1:0]   job_num_vertices,
	output logic                                   remaining_zero,
	output logic                                   cmd_valid,
	output logic [vertex_job_pkg::ADDRESS_BITS-1:0] cmd_address,
	output read_command_pkg::array_sel_t           cmd_array,
	output logic [read_command_pkg::CHUNK_BITS-1:0] cmd_count
);

	import vertex_job_pkg::*;
	import read_command_pkg::*;

	logic [ADDRESS_BITS-1:0] degree_base;
	logic [ADDRESS_BITS-1:0] edges_base;
	logic [COUNT_BITS-1:0]   remaining;
	logic [ADDRESS_BITS-1:0] offset;
	logic [CHUNK_BITS-1:0]   chunk;

	// full line, or whatever is left for the last one
	assign chunk = (remaining > COUNT_BITS'(LINE_VERTICES)) ?
		CHUNK_BITS'(LINE_VERTICES) : remaining[CHUNK_BITS-1:0];
	assign remaining_zero = (remaining == '0);

	always_ff @(posedge clock) begin
		if (chunk_load) begin
			degree_base <= job_degree_base;
			edges_base  <= job_edges_base;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			remaining <= '0;
			offset    <= '0;
			cmd_valid <= 1'b0;
		end else begin
			cmd_valid <= issue_degree || issue_edges;
			if (chunk_load) begin
				remaining <= job_num_vertices;
				offset    <= '0;
			end else if (issue_edges) begin
				remaining <= remaining - COUNT_BITS'(chunk);
				offset    <= offset + ADDRESS_BITS'(LINE_BYTES);
			end
		end
	end

	// command payload
	always_ff @(posedge clock) begin
		if (issue_degree || issue_edges) begin
			cmd_address <= (issue_degree ? degree_base : edges_base) + offset;
			cmd_array   <= issue_degree ? ARRAY_OUT_DEGREE : ARRAY_EDGES_IDX;
			cmd_count   <= chunk;
		end
	end

endmodule

`default_nettype wire

// File: hw/vertex_job_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module vertex_job_fsm (
	input  logic clock,
	input  logic rstn,
	input  logic job_start,
	input  logic fifo_empty,
	input  logic remaining_zero,
	input  logic line_pair_ready,
	input  logic shift_done,
	output logic chunk_load,
	output logic issue_degree,
	output logic issue_edges,
	output logic shift_start,
	output logic busy
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOAD,
		ST_WAIT_EMPTY,
		ST_ISSUE_DEGREE,
		ST_ISSUE_EDGES,
		ST_WAIT_DATA,
		ST_SHIFT
	} job_state_t;

	job_state_t state;
	job_state_t next_state;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state <= ST_IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			ST_IDLE: begin
				if (job_start) begin
					next_state = ST_LOAD;
				end
			end
			// counter holds the new job here
			ST_LOAD: begin
				if (remaining_zero) begin
					next_state = ST_IDLE;
				end else if (fifo_empty) begin
					next_state = ST_ISSUE_DEGREE;
				end else begin
					next_state = ST_WAIT_EMPTY;
				end
			end
			ST_WAIT_EMPTY: begin
				if (fifo_empty) begin
					next_state = ST_ISSUE_DEGREE;
				end
			end
			ST_ISSUE_DEGREE: next_state = ST_ISSUE_EDGES;
			ST_ISSUE_EDGES:  next_state = ST_WAIT_DATA;
			ST_WAIT_DATA: begin
				if (line_pair_ready) begin
					next_state = ST_SHIFT;
				end
			end
			ST_SHIFT: begin
				if (shift_done) begin
					next_state = remaining_zero ? ST_IDLE : ST_WAIT_EMPTY;
				end
			end
			default: next_state = ST_IDLE;
		endcase
	end

	assign chunk_load   = (state == ST_IDLE) && job_start;
	assign issue_degree = (state == ST_ISSUE_DEGREE);
	assign issue_edges  = (state == ST_ISSUE_EDGES);
	assign shift_start  = (state == ST_WAIT_DATA) && line_pair_ready;
	assign busy         = (state != ST_IDLE);

	////////////////////////////////////////
	// checks
	////////////////////////////////////////

	// a new job only while the previous one is finished
	job_start_idle: assert property (@(posedge clock) disable iff (!rstn)
		job_start |-> !busy);

endmodule

`default_nettype wire

// File: hw/read_command_pkg.sv
`default_nettype none

package read_command_pkg;

	////////////////////////////////////////
	// read command fields
	////////////////////////////////////////

	// which array a command or a returned line belongs to
	typedef enum logic {
		ARRAY_OUT_DEGREE = 1'b0,
		ARRAY_EDGES_IDX  = 1'b1
	} array_sel_t;

	// vertex count of one command, up to a full line
	localparam int CHUNK_BITS = 3;

endpackage

`default_nettype wire

// File: hw/vertex_job_pkg.sv
`default_nettype none

package vertex_job_pkg;

	////////////////////////////////////////
	// vertex and line geometry
	////////////////////////////////////////

	// one vertex entry, also the width of a vertex id
	localparam int VERTEX_BITS = 32;

	localparam int LINE_BYTES = 16;
	localparam int LINE_BITS = LINE_BYTES * 8;

	// entries carried by one returned line
	localparam int LINE_VERTICES = LINE_BITS / VERTEX_BITS;

	// byte addresses of the two arrays
	localparam int ADDRESS_BITS = 32;

	// vertex counts of a whole job
	localparam int COUNT_BITS = 32;

	////////////////////////////////////////
	// job queue
	////////////////////////////////////////

	// holds at least one full line of vertices
	localparam int VERTEX_FIFO_DEPTH = 8;

	// returned line, flat when loaded, per entry when unpacked
	// entry 0 sits in the low bits
	typedef union packed {
		logic [LINE_BITS-1:0]                        word;
		logic [LINE_VERTICES-1:0][VERTEX_BITS-1:0]   entry;
	} vertex_line_t;

endpackage

`default_nettype wire
